// File: rtl/trace_pkg.sv
/*
 * shared widths, command codes and the FIFO payload layout
 * for the trace-port front end; imported by the RTL blocks
 */
package trace_pkg;

   //////////////////////////////////////////////////////////////
   // trace window and rules
   //////////////////////////////////////////////////////////////

   // window width, sync test below assumes 64
   localparam int frame_bits = 64;
   // upper bound on rules, also match-rule field width
   localparam int max_rules  = 8;
   // per-rule hit counter
   localparam int count_bits = 8;

   // newest end of window must hold this for lock
   localparam logic [15:0] sync_head = 16'h7fff;
   // oldest byte of window
   localparam logic [7:0]  sync_tail = 8'hff;

   //////////////////////////////////////////////////////////////
   // FIFO word
   //////////////////////////////////////////////////////////////

   localparam int cmd_bits        = 2;
   localparam int short_time_bits = 8;
   localparam int full_time_bits  = 16;
   // command on top, 16-bit payload below
   localparam int fifo_word_bits  = cmd_bits + full_time_bits;

   localparam logic [cmd_bits-1:0] cmd_data = 2'd0;
   localparam logic [cmd_bits-1:0] cmd_stat = 2'd1;
   localparam logic [cmd_bits-1:0] cmd_time = 2'd2;

   // data word: short time over the rule bits
   typedef struct packed {
      logic [short_time_bits-1:0] short_time;
      logic [max_rules-1:0]       rule;
   } data_fields_t;

   // time word: full timestamp only
   typedef struct packed {
      logic [full_time_bits-1:0] full_time;
   } time_fields_t;

   typedef union packed {
      data_fields_t data_view;
      time_fields_t time_view;
   } fifo_payload_u;

endpackage

// File: rtl/trace_deserializer.sv
/*
 * trace bus deserializer: shifts 1, 2 or 4 bit trace data into a
 * 64-bit window, locks on sync frames and flags byte-aligned cycles
 */
`timescale 1ns/1ps

module trace_deserializer import trace_pkg::*; (
   input  logic                  trace_clk,
   input  logic                  reset,
   input  logic [3:0]            trace_data,
   input  logic [2:0]            trace_width,
   input  logic                  reset_sync,
   output logic [frame_bits-1:0] frame,
   output logic                  trace_synced,
   output logic                  byte_strobe
);

   // raw shift register, newest bits at the lsb end
   logic [frame_bits-1:0] buffer;
   // width seen last cycle, for change detect
   logic [2:0]            trace_width_q;
   // cycles since lock, wraps freely
   logic [2:0]            phase_count;
   logic                  sync_seen;

   //////////////////////////////////////////////////////////////
   // shift buffer
   //////////////////////////////////////////////////////////////

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         buffer <= '0;
      end else begin
         // bit 0 is the oldest on the bus
         case (trace_width)
            3'd4:    buffer <= {buffer[frame_bits-5:0], trace_data[0], trace_data[1],
                                trace_data[2], trace_data[3]};
            3'd2:    buffer <= {buffer[frame_bits-3:0], trace_data[0], trace_data[1]};
            default: buffer <= {buffer[frame_bits-2:0], trace_data[0]};
         endcase
      end
   end

   // flip so the newest bits land on top
   assign frame = {<<{buffer}};

   //////////////////////////////////////////////////////////////
   // sync lock
   //////////////////////////////////////////////////////////////

   // head at the newest end, tail at the oldest
   assign sync_seen = (frame[frame_bits-1 -: 16] == sync_head) &&
                      (frame[7:0] == sync_tail);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         trace_synced  <= 1'b0;
         phase_count   <= '0;
         trace_width_q <= '0;
      end else begin
         trace_width_q <= trace_width;
         // forced resync or width change drops lock
         if (reset_sync || (trace_width != trace_width_q)) begin
            trace_synced <= 1'b0;
            phase_count  <= '0;
         end else if (!trace_synced && sync_seen) begin
            trace_synced <= 1'b1;
            phase_count  <= 3'd1;
         end else if (trace_synced) begin
            phase_count  <= phase_count + 3'd1;
         end
      end
   end

   // byte boundary every 8, 4 or 2 cycles
   always_comb begin
      case (trace_width)
         3'd1:    byte_strobe = trace_synced && (phase_count == 3'd0);
         3'd2:    byte_strobe = trace_synced && (phase_count[1:0] == 2'd0);
         3'd4:    byte_strobe = trace_synced && !phase_count[0];
         default: byte_strobe = 1'b0;
      endcase
   end

endmodule

// File: rtl/trace_rule_matcher.sv
/*
 * masked pattern rules over the aligned trace window, with per-rule
 * hit counters, the latched match rule and the armed trigger
 */
`timescale 1ns/1ps

module trace_rule_matcher import trace_pkg::*; #(
   parameter int num_rules = 8
) (
   input  logic                                 trace_clk,
   input  logic                                 reset,
   input  logic [frame_bits-1:0]                frame,
   input  logic                                 byte_strobe,
   input  logic                                 capturing,
   input  logic [num_rules-1:0][frame_bits-1:0] patterns,
   input  logic [num_rules-1:0][frame_bits-1:0] masks,
   input  logic [num_rules-1:0]                 rule_enable,
   input  logic [num_rules-1:0]                 trig_enable,
   input  logic                                 soft_trig,
   input  logic                                 soft_trig_enable,
   input  logic                                 arm,
   output logic                                 trace_event,
   output logic [num_rules-1:0][count_bits-1:0] hit_counts,
   output logic [max_rules-1:0]                 match_rule,
   output logic                                 trigger
);

   logic [num_rules-1:0] hits;
   logic                 capturing_q;
   // masked hit OR, now and last cycle
   logic                 trig_any;
   logic                 trig_any_q;
   // soft trigger edge detect
   logic                 soft_trig_q;
   logic                 soft_edge;

   //////////////////////////////////////////////////////////////
   // rule compare
   //////////////////////////////////////////////////////////////

   // only at byte boundaries, only while capturing
   for (genvar i = 0; i < num_rules; i++) begin : g_rule
      assign hits[i] = ((frame & masks[i]) == (patterns[i] & masks[i])) &&
                       rule_enable[i] && byte_strobe && capturing_q;
   end

   assign trace_event = |hits;

   // counters wrap at full width
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         hit_counts <= '0;
      end else begin
         for (int i = 0; i < num_rules; i++) begin
            if (hits[i])
               hit_counts[i] <= hit_counts[i] + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////
   // state and trigger
   //////////////////////////////////////////////////////////////

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         capturing_q <= 1'b0;
         trig_any_q  <= 1'b0;
         soft_trig_q <= 1'b0;
         match_rule  <= '0;
      end else begin
         capturing_q <= capturing;
         trig_any_q  <= trig_any;
         soft_trig_q <= soft_trig;
         // hold last matching set between hits
         if (trace_event)
            match_rule <= max_rules'(hits);
      end
   end

   assign trig_any  = |(hits & trig_enable);
   assign soft_edge = soft_trig && !soft_trig_q && soft_trig_enable;

   // one trigger per rising edge of either source, armed only
   assign trigger = arm && (soft_edge || (trig_any && !trig_any_q));

endmodule

// File: rtl/trace_fifo_writer.sv
/*
 * capture FIFO word formatter: registers one command word per
 * request cycle, payload chosen by the command code
 */
`timescale 1ns/1ps

module trace_fifo_writer import trace_pkg::*; (
   input  logic                      trace_clk,
   input  logic                      reset,
   input  logic                      fifo_wr_req,
   input  logic [cmd_bits-1:0]       fifo_cmd,
   input  logic [full_time_bits-1:0] fifo_time,
   input  logic [max_rules-1:0]      match_rule,
   output logic [fifo_word_bits-1:0] fifo_data,
   output logic                      fifo_wr
);

   fifo_payload_u payload;

   //////////////////////////////////////////////////////////////
   // payload select
   //////////////////////////////////////////////////////////////

   always_comb begin
      payload = '0;
      case (fifo_cmd)
         // short time plus the rule bits
         cmd_data: begin
            payload.data_view.short_time = fifo_time[short_time_bits-1:0];
            payload.data_view.rule       = match_rule;
         end
         // whole timestamp
         cmd_time: payload.time_view.full_time = fifo_time;
         // no raw capture, status word carries nothing
         cmd_stat: payload = '0;
         default:  payload = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////
   // output registers
   //////////////////////////////////////////////////////////////

   always_ff @(posedge trace_clk) begin
      if (reset)
         fifo_wr <= 1'b0;
      else
         fifo_wr <= fifo_wr_req;
   end

   // word only loads on a request
   always_ff @(posedge trace_clk) begin
      if (fifo_wr_req)
         fifo_data <= {fifo_cmd, payload};
   end

endmodule

// File: rtl/trace_frontend.sv
/*
 * ARM trace-port front end top level; connects the deserializer,
 * the rule matcher and the FIFO word writer
 */
`timescale 1ns/1ps

module trace_frontend import trace_pkg::*; #(
   parameter int num_rules = 8
) (
   input  logic                                 trace_clk,
   input  logic                                 reset,
   // trace bus
   input  logic [3:0]                           trace_data,
   input  logic [2:0]                           trace_width,
   input  logic                                 reset_sync,
   input  logic                                 capturing,
   // rule setup
   input  logic [num_rules-1:0][frame_bits-1:0] patterns,
   input  logic [num_rules-1:0][frame_bits-1:0] masks,
   input  logic [num_rules-1:0]                 rule_enable,
   input  logic [num_rules-1:0]                 trig_enable,
   input  logic                                 soft_trig,
   input  logic                                 soft_trig_enable,
   input  logic                                 arm,
   // FIFO requests
   input  logic                                 fifo_wr_req,
   input  logic [cmd_bits-1:0]                  fifo_cmd,
   input  logic [full_time_bits-1:0]            fifo_time,
   // status and results
   output logic                                 trace_synced,
   output logic                                 trace_event,
   output logic [num_rules-1:0][count_bits-1:0] hit_counts,
   output logic                                 trigger,
   output logic [fifo_word_bits-1:0]            fifo_data,
   output logic                                 fifo_wr
);

   logic [frame_bits-1:0] frame;
   logic                  byte_strobe;
   logic [max_rules-1:0]  match_rule;

   trace_deserializer u_deser (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .trace_data   (trace_data),
      .trace_width  (trace_width),
      .reset_sync   (reset_sync),
      .frame        (frame),
      .trace_synced (trace_synced),
      .byte_strobe  (byte_strobe)
   );

   trace_rule_matcher #(
      .num_rules (num_rules)
   ) u_match (
      .trace_clk        (trace_clk),
      .reset            (reset),
      .frame            (frame),
      .byte_strobe      (byte_strobe),
      .capturing        (capturing),
      .patterns         (patterns),
      .masks            (masks),
      .rule_enable      (rule_enable),
      .trig_enable      (trig_enable),
      .soft_trig        (soft_trig),
      .soft_trig_enable (soft_trig_enable),
      .arm              (arm),
      .trace_event      (trace_event),
      .hit_counts       (hit_counts),
      .match_rule       (match_rule),
      .trigger          (trigger)
   );

   // rule bits reach the FIFO one cycle after the hit
   trace_fifo_writer u_fifo (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .fifo_wr_req (fifo_wr_req),
      .fifo_cmd    (fifo_cmd),
      .fifo_time   (fifo_time),
      .match_rule  (match_rule),
      .fifo_data   (fifo_data),
      .fifo_wr     (fifo_wr)
   );

endmodule

// File: test/trace_frontend_chk.sv
/*
 * concurrent checks on the trace front end, bound into trace_frontend;
 * each failed check raises $error and bumps fail_count for the testbench
 */
`timescale 1ns/1ps

module trace_frontend_chk import trace_pkg::*; (
   input logic                      trace_clk,
   input logic                      reset,
   input logic                      trace_synced,
   input logic                      trace_event,
   input logic                      byte_strobe,
   input logic                      trigger,
   input logic                      arm,
   input logic                      soft_trig,
   input logic                      soft_trig_enable,
   input logic                      fifo_wr_req,
   input logic                      fifo_wr,
   input logic [cmd_bits-1:0]       fifo_cmd,
   input logic [full_time_bits-1:0] fifo_time,
   input logic [fifo_word_bits-1:0] fifo_data,
   input logic [max_rules-1:0]      match_rule
);

   int fail_count = 0;

   task automatic record_failure(input string what);
      $error("%s", what);
      fail_count++;
   endtask

   //////////////////////////////////////////////////////////////
   // status and trigger
   //////////////////////////////////////////////////////////////

   // first cycle out of reset is quiet
   a_idle: assert property (@(posedge trace_clk)
      $fell(reset) |-> !(trace_synced || trace_event || fifo_wr || trigger))
      else record_failure("outputs active right after reset");

   // events only on byte boundaries of a locked stream
   a_event: assert property (@(posedge trace_clk) disable iff (reset)
      trace_event |-> trace_synced && byte_strobe)
      else record_failure("trace_event off a locked byte strobe");

   a_armed: assert property (@(posedge trace_clk) disable iff (reset)
      trigger |-> arm)
      else record_failure("trigger while not armed");

   a_soft: assert property (@(posedge trace_clk) disable iff (reset)
      arm && soft_trig_enable && $rose(soft_trig) |-> trigger)
      else record_failure("soft trigger edge gave no trigger");

   // rule trigger needs a match and cannot repeat next cycle
   a_edge: assert property (@(posedge trace_clk) disable iff (reset)
      trigger && !(soft_trig_enable && $rose(soft_trig)) |->
         trace_event ##1 !(trigger && !(soft_trig_enable && $rose(soft_trig))))
      else record_failure("rule trigger not on a rising match edge");

   //////////////////////////////////////////////////////////////
   // FIFO words
   //////////////////////////////////////////////////////////////

   a_wr: assert property (@(posedge trace_clk) disable iff (reset)
      fifo_wr == $past(fifo_wr_req))
      else record_failure("fifo_wr not one cycle after fifo_wr_req");

   // short time over the rule bits seen at request time
   a_data: assert property (@(posedge trace_clk) disable iff (reset)
      fifo_wr_req && fifo_cmd == cmd_data |=> fifo_data ==
         {cmd_data, $past(fifo_time[short_time_bits-1:0]), $past(match_rule)})
      else record_failure("data word fields wrong");

   a_time: assert property (@(posedge trace_clk) disable iff (reset)
      fifo_wr_req && fifo_cmd == cmd_time |=> fifo_data == {cmd_time, $past(fifo_time)})
      else record_failure("time word fields wrong");

   // status word has no payload without raw capture
   a_stat: assert property (@(posedge trace_clk) disable iff (reset)
      fifo_wr_req && fifo_cmd == cmd_stat |=> fifo_data == {cmd_stat, 16'h0000})
      else record_failure("status word payload not zero");

endmodule

bind trace_frontend trace_frontend_chk u_chk (.*);

// File: test/trace_frontend_tb.sv
/*
 * testbench for the trace front end: locks at widths 1, 2 and 4, runs
 * random trace data past masked rules and checks lock, byte strobes and
 * hit counters against its own model; the bound checker holds the assertions
 */
`timescale 1ns/1ps

module trace_frontend_tb import trace_pkg::*; ();

   localparam int num_rules = 8;

   logic                                 trace_clk = 1'b0;
   logic                                 reset = 1'b1;
   logic [3:0]                           trace_data = '0;
   logic [2:0]                           trace_width = 3'd1;
   logic                                 reset_sync = 1'b0;
   logic                                 capturing = 1'b0;
   logic [num_rules-1:0][frame_bits-1:0] patterns = '0;
   logic [num_rules-1:0][frame_bits-1:0] masks = '1;
   // rule 5 stays off, rule 6 drives the rule trigger
   logic [num_rules-1:0]                 rule_enable = 8'b1101_1111;
   logic [num_rules-1:0]                 trig_enable = 8'b0100_0000;
   logic                                 soft_trig = 1'b0;
   logic                                 soft_trig_enable = 1'b0;
   logic                                 arm = 1'b0;
   logic                                 fifo_wr_req = 1'b0;
   logic [cmd_bits-1:0]                  fifo_cmd = cmd_data;
   logic [full_time_bits-1:0]            fifo_time = '0;
   logic                                 trace_synced;
   logic                                 trace_event;
   logic                                 trigger;
   logic                                 fifo_wr;
   logic [num_rules-1:0][count_bits-1:0] hit_counts;
   logic [fifo_word_bits-1:0]            fifo_data;

   // reference model state
   logic [frame_bits-1:0] model_frame;
   logic [2:0]            width_q;
   logic                  exp_synced;
   // beats since lock
   int                    exp_phase;
   // capturing as the rules see it, one cycle late
   logic                  capture_q;
   logic [count_bits-1:0] exp_count [num_rules];
   int                    count_errors = 0;
   int                    model_errors = 0;

   trace_frontend #(.num_rules(num_rules)) DUT (.*);

   always #5 trace_clk = ~trace_clk;

   //////////////////////////////////////////////////////////////
   // shift model, lock model and counter compare
   //////////////////////////////////////////////////////////////

   // a byte takes 8 / width beats, other widths never align
   function automatic logic byte_aligned(input logic [2:0] width, input int phase);
      if (width != 3'd1 && width != 3'd2 && width != 3'd4)
         return 1'b0;
      return (phase % (8 / int'(width))) == 0;
   endfunction

   always @(posedge trace_clk) begin : model
      logic hit;
      logic any_hit;
      logic strobe;
      any_hit = 1'b0;
      strobe  = exp_synced && byte_aligned(trace_width, exp_phase);
      if (reset) begin
         model_frame <= '0;
         exp_synced  <= 1'b0;
         exp_phase   <= 0;
         capture_q   <= 1'b0;
         for (int i = 0; i < num_rules; i++)
            exp_count[i] <= '0;
      end else begin
         if (trace_synced !== exp_synced) begin
            $display("[FAIL] %0t: trace_synced is %b, model says %b",
                     $time, trace_synced, exp_synced);
            model_errors++;
         end
         for (int i = 0; i < num_rules; i++) begin
            hit = strobe && capture_q && rule_enable[i] &&
                  ((model_frame & masks[i]) == (patterns[i] & masks[i]));
            any_hit |= hit;
            if (hit)
               exp_count[i] <= exp_count[i] + 1'b1;
            if (hit_counts[i] !== exp_count[i]) begin
               $display("[FAIL] %0t: rule %0d count is %0d, model says %0d",
                        $time, i, hit_counts[i], exp_count[i]);
               count_errors++;
            end
         end
         if (trace_event !== any_hit) begin
            $display("[FAIL] %0t: trace_event is %b, model says %b",
                     $time, trace_event, any_hit);
            model_errors++;
         end
         // newest bits enter at the top
         case (trace_width)
            3'd4:    model_frame <= {trace_data, model_frame[frame_bits-1:4]};
            3'd2:    model_frame <= {trace_data[1:0], model_frame[frame_bits-1:2]};
            default: model_frame <= {trace_data[0], model_frame[frame_bits-1:1]};
         endcase
         capture_q <= capturing;
         if (reset_sync || trace_width != width_q) begin
            exp_synced <= 1'b0;
            exp_phase  <= 0;
         end else if (!exp_synced && model_frame[frame_bits-1 -: 16] == 16'h7fff &&
                      model_frame[7:0] == 8'hff) begin
            exp_synced <= 1'b1;
            exp_phase  <= 1;
         end else if (exp_synced) begin
            exp_phase  <= exp_phase + 1;
         end
      end
      width_q <= trace_width;
   end

   //////////////////////////////////////////////////////////////
   // stimulus tasks
   //////////////////////////////////////////////////////////////

   task automatic abort_on_timeout(input string what);
      $display("timeout: %s did not happen in time", what);
      $display("TEST RESULT: FAIL");
      $finish;
   endtask

   task automatic beat(input logic [3:0] d);
      @(posedge trace_clk);
      trace_data <= d;
   endtask

   // ones, then one zero as the newest bit, then data until lock
   task automatic lock_at(input logic [2:0] w);
      int n;
      @(posedge trace_clk);
      trace_width <= w;
      repeat (70) beat(4'hf);
      beat(4'hf & ~(4'h1 << (w - 3'd1)));
      n = 0;
      @(negedge trace_clk);
      while (!trace_synced && n < 40) begin
         beat(4'($urandom));
         @(negedge trace_clk);
         n++;
      end
      if (!trace_synced)
         abort_on_timeout("sync lock");
   endtask

   task automatic fifo_write(input logic [cmd_bits-1:0] cmd);
      int n;
      @(posedge trace_clk);
      fifo_wr_req <= 1'b1;
      fifo_cmd    <= cmd;
      fifo_time   <= 16'($urandom);
      @(posedge trace_clk);
      fifo_wr_req <= 1'b0;
      n = 0;
      @(negedge trace_clk);
      while (!fifo_wr && n < 4) begin
         @(negedge trace_clk);
         n++;
      end
      if (!fifo_wr)
         abort_on_timeout("fifo_wr");
   endtask

   initial begin
      logic [2:0] w;
      int         k;
      void'($urandom(24));
      repeat (4) @(posedge trace_clk);
      reset <= 1'b0;
      for (int j = 0; j < 3; j++) begin
         w = 3'd1 << j;
         // width change also drops the previous lock
         lock_at(w);
         @(posedge trace_clk);
         capturing        <= 1'b1;
         arm              <= (j != 0);
         soft_trig_enable <= 1'b1;
         // one random byte lane of the model frame per rule
         for (int i = 0; i < 5; i++) begin
            k = $urandom_range(7);
            masks[i]    <= 64'hff << (8 * k);
            patterns[i] <= model_frame;
         end
         // rule 6 hits every strobe, rule 7 wants an all-ones newest byte
         masks[6]    <= '0;
         masks[7]    <= 64'hff << 56;
         patterns[7] <= '1;
         repeat (300) beat(4'($urandom));
         repeat (40) beat(4'hf);
         @(posedge trace_clk);
         soft_trig <= 1'b1;
         repeat (2) @(posedge trace_clk);
         soft_trig <= 1'b0;
         fifo_write(cmd_data);
         fifo_write(cmd_time);
         fifo_write(cmd_stat);
      end
      // forced resync on the last lock
      @(posedge trace_clk);
      reset_sync <= 1'b1;
      @(posedge trace_clk);
      reset_sync <= 1'b0;
      repeat (4) @(posedge trace_clk);
      $display("errors: %0d counter, %0d model, %0d assertion",
               count_errors, model_errors, DUT.u_chk.fail_count);
      if (count_errors + model_errors + DUT.u_chk.fail_count == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: flist.f
rtl/trace_pkg.sv
rtl/trace_deserializer.sv
rtl/trace_rule_matcher.sv
rtl/trace_fifo_writer.sv
rtl/trace_frontend.sv
test/trace_frontend_chk.sv
test/trace_frontend_tb.sv

// File: Bender.yml
package:
  name: trace_frontend

sources:
  - rtl/trace_pkg.sv
  - rtl/trace_deserializer.sv
  - rtl/trace_rule_matcher.sv
  - rtl/trace_fifo_writer.sv
  - rtl/trace_frontend.sv
  - target: test
    files:
      - test/trace_frontend_chk.sv
      - test/trace_frontend_tb.sv
